// File: hdl/busPkg.sv
// Internal bus types and address layout shared by the requesters, the arbiter and the slaves
`default_nettype none

package busPkg;

// --------------------------------------------------
// Bus sizing
// --------------------------------------------------
localparam int SLAVE_NUM = 2;
localparam int SLAVE_IDX_BITS = $clog2(SLAVE_NUM);
localparam logic [SLAVE_IDX_BITS-1:0] SLAVE_LAST = SLAVE_IDX_BITS'(SLAVE_NUM - 1);
localparam int ADRS_BITS = 16;

// Slave field on top, register index at the bottom
localparam int SEL_BITS = 4;
localparam int REG_BITS = 2;
localparam logic [REG_BITS-1:0] STATUS_REG = 2'd3;

typedef enum logic {
	cmdWrite = 1'b0,
	cmdRead  = 1'b1
} busCmd_e;

// Command and address share one request word
typedef struct packed {
	busCmd_e               cmd;
	logic [ADRS_BITS-1:0]  adrs;
	logic [31:0]           wd;
} busReq_t;

typedef struct packed {
	logic [31:0]           rd;
	logic [SLAVE_NUM-1:0]  vd;
} busRsp_t;

function automatic logic [SEL_BITS-1:0] adrsSel(input logic [ADRS_BITS-1:0] adrs);
	return adrs[ADRS_BITS-1 -: SEL_BITS];
endfunction

function automatic logic [REG_BITS-1:0] adrsReg(input logic [ADRS_BITS-1:0] adrs);
	return adrs[REG_BITS-1:0];
endfunction

// Build a register address for a slave index
function automatic logic [ADRS_BITS-1:0] makeAdrs(
	input logic [SLAVE_IDX_BITS-1:0] idx,
	input logic [REG_BITS-1:0]       regIdx
);
	logic [ADRS_BITS-1:0] adrs;
	adrs = '0;
	adrs[ADRS_BITS-SEL_BITS +: SLAVE_IDX_BITS] = idx;
	adrs[REG_BITS-1:0] = regIdx;
	return adrs;
endfunction

endpackage

`default_nettype wire

// File: hdl/ctrlPkg.sv
// Host link constants for the UART, the command port and the poller, also used by the testbench
`default_nettype none

package ctrlPkg;

// --------------------------------------------------
// Host frame protocol
// --------------------------------------------------
typedef enum logic [7:0] {
	opWrite = 8'h57,
	opRead  = 8'h52,
	opAuto  = 8'h41
} hostOp_e;

// Single byte replies
localparam logic [7:0] REPLY_ACK = 8'h55;
localparam logic [7:0] REPLY_ERR = 8'hEE;

// Opcode, two address bytes, four data bytes
localparam int FRAME_BYTES = 7;
localparam logic [2:0] FRAME_LAST = 3'(FRAME_BYTES - 1);

// --------------------------------------------------
// Timing
// --------------------------------------------------
localparam int CLKS_PER_BIT = 8;
localparam int BIT_CNT_BITS = $clog2(CLKS_PER_BIT);
localparam logic [BIT_CNT_BITS-1:0] BIT_LAST = BIT_CNT_BITS'(CLKS_PER_BIT - 1);
localparam logic [BIT_CNT_BITS-1:0] BIT_HALF = BIT_CNT_BITS'(CLKS_PER_BIT / 2 - 1);

localparam int POLL_PERIOD = 64;
localparam int POLL_CNT_BITS = $clog2(POLL_PERIOD);
localparam logic [POLL_CNT_BITS-1:0] POLL_LAST = POLL_CNT_BITS'(POLL_PERIOD - 1);

endpackage

`default_nettype wire

// File: hdl/uartLink.sv
// Serial byte link to the host, strobes each received byte and sends one byte per strobe
`default_nettype none

module uartLink (
	input  wire logic        sysClk,
	input  wire logic        rstN,
	input  wire logic        uartRx,
	output logic             uartTx,
	output logic [7:0]       rxByte,
	output logic             rxStb,
	input  wire logic [7:0]  txByte,
	input  wire logic        txStb,
	output logic             txBusy
);

// --------------------------------------------------
// Receiver
// --------------------------------------------------
typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxState_e;

rxState_e                         rxState;
logic                             rxMeta;
logic                             rxSync;
logic [ctrlPkg::BIT_CNT_BITS-1:0] rxCnt;
logic [2:0]                       rxBitIdx;
logic [7:0]                       rxShift;

// Shift register holds the finished byte while rxStb is high
assign rxByte = rxShift;

always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		rxMeta   <= 1'b1;
		rxSync   <= 1'b1;
		rxState  <= rxIdle;
		rxCnt    <= '0;
		rxBitIdx <= '0;
		rxShift  <= '0;
		rxStb    <= 1'b0;
	end
	else
	begin
		// Two flop synchronizer
		rxMeta <= uartRx;
		rxSync <= rxMeta;
		rxStb  <= 1'b0;
		rxCnt  <= rxCnt + 1'b1;
		case (rxState)
			rxIdle:
			begin
				rxCnt <= '0;
				if (!rxSync)
					rxState <= rxStart;
			end
			rxStart:
			begin
				// Middle of start bit, glitch goes back to idle
				if (rxCnt == ctrlPkg::BIT_HALF)
				begin
					rxCnt    <= '0;
					rxBitIdx <= '0;
					rxState  <= rxSync ? rxIdle : rxData;
				end
			end
			rxData:
			begin
				if (rxCnt == ctrlPkg::BIT_LAST)
				begin
					// LSB first
					rxShift  <= {rxSync, rxShift[7:1]};
					rxBitIdx <= rxBitIdx + 1'b1;
					if (rxBitIdx == 3'd7)
						rxState <= rxStop;
				end
			end
			default:
			begin
				// Mid stop bit, no framing check
				if (rxCnt == ctrlPkg::BIT_LAST)
				begin
					rxStb   <= 1'b1;
					rxState <= rxIdle;
				end
			end
		endcase
	end
end

// --------------------------------------------------
// Transmitter
// --------------------------------------------------
logic [9:0]                       txShift;
logic [ctrlPkg::BIT_CNT_BITS-1:0] txCnt;
logic [3:0]                       txBitIdx;

// Idle line is high since ones shift in behind the frame
assign uartTx = txShift[0];

always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		txShift  <= '1;
		txCnt    <= '0;
		txBitIdx <= '0;
		txBusy   <= 1'b0;
	end
	else if (!txBusy)
	begin
		if (txStb)
		begin
			// Stop, data, start
			txShift  <= {1'b1, txByte, 1'b0};
			txCnt    <= '0;
			txBitIdx <= '0;
			txBusy   <= 1'b1;
		end
	end
	else if (txCnt == ctrlPkg::BIT_LAST)
	begin
		txCnt    <= '0;
		txShift  <= {1'b1, txShift[9:1]};
		txBitIdx <= txBitIdx + 1'b1;
		// Busy until the stop bit has run its full length
		if (txBitIdx == 4'd9)
			txBusy <= 1'b0;
	end
	else
		txCnt <= txCnt + 1'b1;
end

endmodule

`default_nettype wire

// File: hdl/hostCommandPort.sv
// Host command port, turns UART frames into bus cycles or snapshot reads and sends the reply bytes
`default_nettype none

module hostCommandPort (
	input  wire logic                          sysClk,
	input  wire logic                          rstN,
	input  wire logic [7:0]                    rxByte,
	input  wire logic                          rxStb,
	output logic [7:0]                         txByte,
	output logic                               txStb,
	input  wire logic                          txBusy,
	output logic                               req,
	output busPkg::busReq_t                    reqBus,
	input  wire logic                          done,
	input  wire busPkg::busRsp_t               rsp,
	output logic [busPkg::SLAVE_IDX_BITS-1:0]  snapSel,
	input  wire logic [31:0]                   snapRd
);

typedef enum logic [2:0] {stIdle, stCollect, stBusWait, stReply, stSendBytes} state_e;

state_e                       state;
logic [2:0]                   byteCnt;
logic [47:0]                  frameSr;
logic [55:0]                  frame;
logic [7:0]                   frameOp;
logic [busPkg::ADRS_BITS-1:0] frameAdrs;
logic [31:0]                  frameData;
logic [busPkg::SEL_BITS-1:0]  frameSel;
logic [31:0]                  txData;
logic [2:0]                   txLen;

// Whole frame including the byte arriving now
assign frame     = {frameSr, rxByte};
assign frameOp   = frame[55:48];
assign frameAdrs = frame[47:32];
assign frameData = frame[31:0];
assign frameSel  = busPkg::adrsSel(frameAdrs);

always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		state   <= stIdle;
		byteCnt <= '0;
		frameSr <= '0;
		req     <= 1'b0;
		reqBus  <= '0;
		snapSel <= '0;
		txData  <= '0;
		txLen   <= '0;
		txByte  <= '0;
		txStb   <= 1'b0;
	end
	else
	begin
		txStb <= 1'b0;
		case (state)
			stIdle:
			begin
				if (rxStb)
				begin
					frameSr <= {frameSr[39:0], rxByte};
					byteCnt <= 3'd1;
					state   <= stCollect;
				end
			end
			stCollect:
			begin
				if (rxStb)
				begin
					frameSr <= {frameSr[39:0], rxByte};
					byteCnt <= byteCnt + 3'd1;
					if (byteCnt == ctrlPkg::FRAME_LAST)
					begin
						// Last byte in, decode opcode
						case (frameOp)
							ctrlPkg::opWrite, ctrlPkg::opRead:
							begin
								reqBus.cmd  <= (frameOp == ctrlPkg::opWrite) ?
									busPkg::cmdWrite : busPkg::cmdRead;
								reqBus.adrs <= frameAdrs;
								reqBus.wd   <= frameData;
								req         <= 1'b1;
								state       <= stBusWait;
							end
							ctrlPkg::opAuto:
							begin
								// Snapshot path, bus untouched
								snapSel <= frameSel[busPkg::SLAVE_IDX_BITS-1:0];
								state   <= stReply;
							end
							default:
							begin
								txData <= {ctrlPkg::REPLY_ERR, 24'd0};
								txLen  <= 3'd1;
								state  <= stSendBytes;
							end
						endcase
					end
				end
			end
			stBusWait:
			begin
				// Request held until the arbiter's done pulse
				if (done)
				begin
					req   <= 1'b0;
					state <= stSendBytes;
					if (rsp.vd == '0)
					begin
						// Nobody answered, unmapped slave
						txData <= {ctrlPkg::REPLY_ERR, 24'd0};
						txLen  <= 3'd1;
					end
					else if (reqBus.cmd == busPkg::cmdWrite)
					begin
						txData <= {ctrlPkg::REPLY_ACK, 24'd0};
						txLen  <= 3'd1;
					end
					else
					begin
						txData <= rsp.rd;
						txLen  <= 3'd4;
					end
				end
			end
			stReply:
			begin
				txData <= snapRd;
				txLen  <= 3'd4;
				state  <= stSendBytes;
			end
			default:
			begin
				// MSB first, one byte per free transmitter
				if (txLen == 3'd0)
					state <= stIdle;
				else if (!txBusy && !txStb)
				begin
					txByte <= txData[31:24];
					txStb  <= 1'b1;
					txData <= {txData[23:0], 8'd0};
					txLen  <= txLen - 3'd1;
				end
			end
		endcase
	end
end

endmodule

`default_nettype wire

// File: hdl/autoPoller.sv
// Periodic status poller, reads each slave's status register in turn and serves the snapshots
`default_nettype none

module autoPoller (
	input  wire logic                               sysClk,
	input  wire logic                               rstN,
	output logic                                    req,
	output busPkg::busReq_t                         reqBus,
	input  wire logic                               done,
	input  wire busPkg::busRsp_t                    rsp,
	input  wire logic [busPkg::SLAVE_IDX_BITS-1:0]  snapSel,
	output logic [31:0]                             snapRd
);

logic [ctrlPkg::POLL_CNT_BITS-1:0] periodCnt;
logic [busPkg::SLAVE_IDX_BITS-1:0] curSlave;
logic [31:0]                       snap [busPkg::SLAVE_NUM];

always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		periodCnt <= '0;
		curSlave  <= '0;
		req       <= 1'b0;
		reqBus    <= '0;
	end
	else
	begin
		// Free running period
		periodCnt <= (periodCnt == ctrlPkg::POLL_LAST) ? '0 : periodCnt + 1'b1;
		if (periodCnt == ctrlPkg::POLL_LAST && !req)
		begin
			req         <= 1'b1;
			reqBus.cmd  <= busPkg::cmdRead;
			reqBus.adrs <= busPkg::makeAdrs(curSlave, busPkg::STATUS_REG);
			reqBus.wd   <= '0;
		end
		else if (done)
		begin
			// Next slave on the next period
			req      <= 1'b0;
			curSlave <= (curSlave == busPkg::SLAVE_LAST) ? '0 : curSlave + 1'b1;
		end
	end
end

// Latest status word per slave
always_ff @(posedge sysClk)
begin
	if (done)
		snap[curSlave] <= rsp.rd;
end

assign snapRd = snap[snapSel];

endmodule

`default_nettype wire

// File: hdl/busArbiter.sv
// Bus arbiter, grants the bus with host priority, issues one cycle and returns the combined reply
`default_nettype none

module busArbiter (
	input  wire logic                                   sysClk,
	input  wire logic                                   rstN,
	input  wire logic                                   hostReq,
	input  wire busPkg::busReq_t                        hostBus,
	output logic                                        hostDone,
	input  wire logic                                   pollReq,
	input  wire busPkg::busReq_t                        pollBus,
	output logic                                        pollDone,
	output busPkg::busRsp_t                             rsp,
	output busPkg::busReq_t                             bus,
	output logic                                        wCke,
	input  wire busPkg::busRsp_t [busPkg::SLAVE_NUM-1:0] slaveRsp
);

typedef enum logic [1:0] {arbIdle, arbIssue, arbCollect, arbFinish} arbState_e;

arbState_e       state;
logic            hostOwns;
busPkg::busRsp_t rspOr;

// Idle slaves drive zero so a plain OR merges the replies
always_comb
begin
	rspOr = '0;
	for (int i = 0; i < busPkg::SLAVE_NUM; i++)
	begin
		rspOr = rspOr | slaveRsp[i];
	end
end

// --------------------------------------------------
// Grant and cycle sequence
// --------------------------------------------------
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		state    <= arbIdle;
		hostOwns <= 1'b0;
		bus      <= '0;
		wCke     <= 1'b0;
		rsp      <= '0;
		hostDone <= 1'b0;
		pollDone <= 1'b0;
	end
	else
	begin
		case (state)
			arbIdle:
			begin
				// Host first, poller waits
				if (hostReq)
				begin
					hostOwns <= 1'b1;
					bus      <= hostBus;
					wCke     <= 1'b1;
					state    <= arbIssue;
				end
				else if (pollReq)
				begin
					hostOwns <= 1'b0;
					bus      <= pollBus;
					wCke     <= 1'b1;
					state    <= arbIssue;
				end
			end
			arbIssue:
			begin
				// Strobe lasts one cycle only
				wCke  <= 1'b0;
				state <= arbCollect;
			end
			arbCollect:
			begin
				rsp      <= rspOr;
				hostDone <= hostOwns;
				pollDone <= !hostOwns;
				state    <= arbFinish;
			end
			default:
			begin
				hostDone <= 1'b0;
				pollDone <= 1'b0;
				state    <= arbIdle;
			end
		endcase
	end
end

endmodule

`default_nettype wire

// File: hdl/regSlave.sv
// Register slave on the internal bus, three read/write words and a write counting status word
`default_nettype none

module regSlave #(
	parameter int slaveId = 0
)(
	input  wire logic             sysClk,
	input  wire logic             rstN,
	input  wire busPkg::busReq_t  bus,
	input  wire logic             wCke,
	output busPkg::busRsp_t       rsp
);

logic [busPkg::REG_BITS-1:0] regIdx;
logic                        hit;
logic                        wrHit;
logic [31:0]                 regFile [3];
logic [31:0]                 writeCnt;
logic [31:0]                 rdData;

// Address decode
assign regIdx = busPkg::adrsReg(bus.adrs);
assign hit    = wCke && (busPkg::adrsSel(bus.adrs) == slaveId[busPkg::SEL_BITS-1:0]);
// Status word is read only
assign wrHit  = hit && (bus.cmd == busPkg::cmdWrite) && (regIdx != busPkg::STATUS_REG);

always_ff @(posedge sysClk)
begin
	if (wrHit)
	begin
		case (regIdx)
			2'd0:    regFile[0] <= bus.wd;
			2'd1:    regFile[1] <= bus.wd;
			default: regFile[2] <= bus.wd;
		endcase
	end
end

always_comb
begin
	case (regIdx)
		2'd0:    rdData = regFile[0];
		2'd1:    rdData = regFile[1];
		2'd2:    rdData = regFile[2];
		default: rdData = writeCnt;
	endcase
end

always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		writeCnt <= '0;
		rsp      <= '0;
	end
	else
	begin
		if (wrHit)
			writeCnt <= writeCnt + 32'd1;
		// Reply for one cycle after the strobe, zero otherwise
		rsp <= '0;
		if (hit)
		begin
			rsp.vd[slaveId] <= 1'b1;
			if (bus.cmd == busPkg::cmdRead)
				rsp.rd <= rdData;
		end
	end
end

endmodule

`default_nettype wire

// File: hdl/microControllerBlock.sv
// Top level bus master block, UART pins outside, host command and auto poll requesters inside
`default_nettype none

module microControllerBlock (
	input  wire logic  sysClk,
	input  wire logic  rstN,
	input  wire logic  uartRx,
	output wire logic  uartTx
);

// --------------------------------------------------
// Host UART path
// --------------------------------------------------
wire logic [7:0]                          rxByte;
wire logic                                rxStb;
wire logic [7:0]                          txByte;
wire logic                                txStb;
wire logic                                txBusy;

// Requesters toward the arbiter
wire logic                                hostReq;
wire busPkg::busReq_t                     hostBus;
wire logic                                hostDone;
wire logic                                pollReq;
wire busPkg::busReq_t                     pollBus;
wire logic                                pollDone;
wire busPkg::busRsp_t                     arbRsp;
wire logic [busPkg::SLAVE_IDX_BITS-1:0]   snapSel;
wire logic [31:0]                         snapRd;

// Shared bus
wire busPkg::busReq_t                     bus;
wire logic                                wCke;
wire busPkg::busRsp_t [busPkg::SLAVE_NUM-1:0] slaveRsp;

uartLink uartLink_inst (
	.sysClk  (sysClk),
	.rstN    (rstN),
	.uartRx  (uartRx),
	.uartTx  (uartTx),
	.rxByte  (rxByte),
	.rxStb   (rxStb),
	.txByte  (txByte),
	.txStb   (txStb),
	.txBusy  (txBusy)
);

// Manual path
hostCommandPort hostCommandPort_inst (
	.sysClk   (sysClk),
	.rstN     (rstN),
	.rxByte   (rxByte),
	.rxStb    (rxStb),
	.txByte   (txByte),
	.txStb    (txStb),
	.txBusy   (txBusy),
	.req      (hostReq),
	.reqBus   (hostBus),
	.done     (hostDone),
	.rsp      (arbRsp),
	.snapSel  (snapSel),
	.snapRd   (snapRd)
);

// Automatic path
autoPoller autoPoller_inst (
	.sysClk   (sysClk),
	.rstN     (rstN),
	.req      (pollReq),
	.reqBus   (pollBus),
	.done     (pollDone),
	.rsp      (arbRsp),
	.snapSel  (snapSel),
	.snapRd   (snapRd)
);

busArbiter busArbiter_inst (
	.sysClk    (sysClk),
	.rstN      (rstN),
	.hostReq   (hostReq),
	.hostBus   (hostBus),
	.hostDone  (hostDone),
	.pollReq   (pollReq),
	.pollBus   (pollBus),
	.pollDone  (pollDone),
	.rsp       (arbRsp),
	.bus       (bus),
	.wCke      (wCke),
	.slaveRsp  (slaveRsp)
);

// One register slave per slave field value
for (genvar i = 0; i < busPkg::SLAVE_NUM; i++)
begin : slaveGen
	regSlave #(
		.slaveId  (i)
	) regSlave_inst (
		.sysClk  (sysClk),
		.rstN    (rstN),
		.bus     (bus),
		.wCke    (wCke),
		.rsp     (slaveRsp[i])
	);
end

endmodule

`default_nettype wire

// File: bench/microControllerBlock_chk.sv
// Bus timing assertions, bound into the arbiter; the testbench reads the failure tally
`default_nettype none

module microControllerBlock_chk (
	input wire logic             sysClk,
	input wire logic             rstN,
	input wire logic             hostReq,
	input wire logic             hostDone,
	input wire logic             pollReq,
	input wire logic             pollDone,
	input wire logic             wCke,
	input wire busPkg::busRsp_t  rsp
);

// Failure tallies per property
int strobeFails = 0;
int hostFails = 0;
int pollFails = 0;
int vdFails = 0;
int assertFails;

assign assertFails = strobeFails + hostFails + pollFails + vdFails;

// --------------------------------------------------
// Bus cycle timing
// --------------------------------------------------
// Strobe lasts one cycle
strobeOneCycle: assert property (@(posedge sysClk) disable iff (!rstN) wCke |=> !wCke)
else
begin
	strobeFails++;
	$error("wCke stayed high for more than one cycle");
end

// Host alone on an idle bus, fixed three cycles
hostLatency: assert property (@(posedge sysClk) disable iff (!rstN)
	$rose(hostReq) && !pollReq |-> ##3 hostDone)
else
begin
	hostFails++;
	$error("hostDone did not follow an uncontended hostReq after three cycles");
end

// Poller alone on an idle bus
pollLatency: assert property (@(posedge sysClk) disable iff (!rstN)
	$rose(pollReq) && !hostReq |-> ##3 pollDone)
else
begin
	pollFails++;
	$error("pollDone did not follow an uncontended pollReq after three cycles");
end

// At most one slave answers
replyOneHot: assert property (@(posedge sysClk) disable iff (!rstN) $onehot0(rsp.vd))
else
begin
	vdFails++;
	$error("more than one slave valid bit set in the reply");
end

endmodule

bind busArbiter microControllerBlock_chk busChk (
	.sysClk    (sysClk),
	.rstN      (rstN),
	.hostReq   (hostReq),
	.hostDone  (hostDone),
	.pollReq   (pollReq),
	.pollDone  (pollDone),
	.wCke      (wCke),
	.rsp       (rsp)
);

`default_nettype wire

// File: bench/microControllerBlock_tb.sv
// Testbench for the bus master block, plays the UART host through a command table and checks replies
`default_nettype none

module microControllerBlock_tb;

// --------------------------------------------------
// Run constants
// --------------------------------------------------
localparam int RESET_CYCLES = 16;
// Poller must cover both slaves during an idle gap
localparam int IDLE_WAIT = 2 * ctrlPkg::POLL_PERIOD + 16;

// One host command with its expected reply
typedef struct packed {
	logic [7:0]  op;
	logic [15:0] adrs;
	logic [31:0] data;
	logic        idle;
	logic [2:0]  len;
	logic [31:0] exp;
} row_t;

logic sysClk;
logic rstN;
logic uartRx;
logic uartTx;

row_t        rows[$];
logic [31:0] modelRegs [2][3];
logic [31:0] modelCount [2];
int          seed = 32'h88c6_9cb6;
int          cycleCnt;
int          timeoutLimit;

microControllerBlock microControllerBlock_inst (
	.sysClk  (sysClk),
	.rstN    (rstN),
	.uartRx  (uartRx),
	.uartTx  (uartTx)
);

initial
begin
	sysClk = 1'b0;
	forever #5 sysClk = ~sysClk;
end

// --------------------------------------------------
// Reporting
// --------------------------------------------------
task automatic abortRun(input string msg);
	$display("%s", msg);
	$display("TEST FAILED");
	$fatal(1);
endtask

task automatic checkValue(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	if (expected !== actual)
		abortRun($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
endtask

// Slave field on top, register index at the bottom
function automatic logic [15:0] regAddress(input logic [3:0] sel, input logic [1:0] regIdx);
	return {sel, 10'd0, regIdx};
endfunction

// --------------------------------------------------
// Table with register model
// --------------------------------------------------
task automatic addRow(input logic [7:0] op, input logic [15:0] adrs, input logic [31:0] data,
	input logic idle);
	row_t       row;
	logic [3:0] sel;
	logic [1:0] regIdx;
	sel      = adrs[15:12];
	regIdx   = adrs[1:0];
	row.op   = op;
	row.adrs = adrs;
	row.data = data;
	row.idle = idle;
	// Default single error byte
	row.len  = 3'd1;
	row.exp  = {24'd0, ctrlPkg::REPLY_ERR};
	if (op == ctrlPkg::opWrite && sel < 4'd2)
	begin
		if (regIdx != 2'd3)
		begin
			modelRegs[sel[0]][regIdx] = data;
			modelCount[sel[0]] = modelCount[sel[0]] + 32'd1;
		end
		row.exp = {24'd0, ctrlPkg::REPLY_ACK};
	end
	else if (op == ctrlPkg::opRead && sel < 4'd2)
	begin
		row.len = 3'd4;
		row.exp = (regIdx == 2'd3) ? modelCount[sel[0]] : modelRegs[sel[0]][regIdx];
	end
	else if (op == ctrlPkg::opAuto)
	begin
		// Snapshot holds the status word
		row.len = 3'd4;
		row.exp = modelCount[sel[0]];
	end
	rows.push_back(row);
endtask

task automatic buildTable();
	modelCount[0] = '0;
	modelCount[1] = '0;
	// Write and read back every register of both slaves
	for (int s = 0; s < 2; s++)
	begin
		for (int r = 0; r < 3; r++)
		begin
			addRow(ctrlPkg::opWrite, regAddress(4'(s), 2'(r)), $random(seed), 1'b0);
			addRow(ctrlPkg::opRead, regAddress(4'(s), 2'(r)), 32'd0, 1'b0);
		end
	end
	// Extra write so the two counts differ
	addRow(ctrlPkg::opWrite, regAddress(4'd1, 2'd1), $random(seed), 1'b0);
	addRow(ctrlPkg::opRead, regAddress(4'd1, 2'd1), 32'd0, 1'b0);
	addRow(ctrlPkg::opRead, regAddress(4'd0, 2'd3), 32'd0, 1'b0);
	addRow(ctrlPkg::opRead, regAddress(4'd1, 2'd3), 32'd0, 1'b0);
	// Unmapped slave and bad opcode
	addRow(ctrlPkg::opRead, regAddress(4'd5, 2'd1), 32'd0, 1'b0);
	addRow(ctrlPkg::opWrite, regAddress(4'd5, 2'd2), $random(seed), 1'b0);
	addRow(8'h3F, regAddress(4'd0, 2'd1), $random(seed), 1'b0);
	// Snapshots after a quiet gap
	addRow(ctrlPkg::opAuto, regAddress(4'd0, 2'd0), 32'd0, 1'b1);
	addRow(ctrlPkg::opAuto, regAddress(4'd1, 2'd0), 32'd0, 1'b0);
	addRow(ctrlPkg::opWrite, regAddress(4'd0, 2'd2), $random(seed), 1'b0);
	addRow(ctrlPkg::opRead, regAddress(4'd0, 2'd2), 32'd0, 1'b0);
	addRow(ctrlPkg::opRead, regAddress(4'd0, 2'd3), 32'd0, 1'b0);
	addRow(ctrlPkg::opAuto, regAddress(4'd0, 2'd0), 32'd0, 1'b1);
endtask

// --------------------------------------------------
// UART host model
// --------------------------------------------------
// Called on a falling edge, returns on one
task automatic sendBit(input logic b);
	uartRx = b;
	repeat (ctrlPkg::CLKS_PER_BIT) @(negedge sysClk);
endtask

task automatic sendByte(input logic [7:0] b);
	sendBit(1'b0);
	for (int i = 0; i < 8; i++)
	begin
		sendBit(b[i]);
	end
	sendBit(1'b1);
endtask

task automatic sendFrame(input row_t row);
	sendByte(row.op);
	sendByte(row.adrs[15:8]);
	sendByte(row.adrs[7:0]);
	// Data MSB first
	sendByte(row.data[31:24]);
	sendByte(row.data[23:16]);
	sendByte(row.data[15:8]);
	sendByte(row.data[7:0]);
endtask

task automatic receiveByte(output logic [7:0] b);
	while (uartTx)
		@(negedge sysClk);
	// Move to mid start bit
	repeat (ctrlPkg::CLKS_PER_BIT / 2) @(negedge sysClk);
	if (uartTx)
		abortRun("Reply start bit on uartTx did not stay low");
	for (int i = 0; i < 8; i++)
	begin
		repeat (ctrlPkg::CLKS_PER_BIT) @(negedge sysClk);
		b[i] = uartTx;
	end
	repeat (ctrlPkg::CLKS_PER_BIT) @(negedge sysClk);
	if (!uartTx)
		abortRun("Reply stop bit on uartTx was low");
endtask

// Cycle limit scaled from the table length
initial
begin
	cycleCnt = 0;
	forever
	begin
		@(posedge sysClk);
		cycleCnt++;
		if (cycleCnt >= timeoutLimit)
			abortRun($sformatf("Timeout after %0d cycles, a reply never completed", cycleCnt));
	end
end

// --------------------------------------------------
// Main sequence
// --------------------------------------------------
initial
begin
	row_t        row;
	logic [31:0] reply;
	logic [7:0]  b;
	int          idleRows;
	uartRx = 1'b1;
	rstN   = 1'b0;
	buildTable();
	idleRows = 0;
	foreach (rows[i])
	begin
		if (rows[i].idle)
			idleRows++;
	end
	timeoutLimit = rows.size() * 11 * 10 * ctrlPkg::CLKS_PER_BIT * 2
		+ idleRows * IDLE_WAIT + 2 * RESET_CYCLES;

	repeat (RESET_CYCLES) @(negedge sysClk);
	rstN = 1'b1;
	@(negedge sysClk);
	// Quiet state out of reset
	checkValue("reset uartTx", 32'd1, 32'(uartTx));
	checkValue("reset wCke", 32'd0, 32'(microControllerBlock_inst.wCke));
	checkValue("reset hostReq", 32'd0, 32'(microControllerBlock_inst.hostReq));
	checkValue("reset pollReq", 32'd0, 32'(microControllerBlock_inst.pollReq));
	checkValue("reset hostDone", 32'd0, 32'(microControllerBlock_inst.hostDone));
	checkValue("reset pollDone", 32'd0, 32'(microControllerBlock_inst.pollDone));
	checkValue("reset txStb", 32'd0, 32'(microControllerBlock_inst.txStb));

	// Back to back frames while the poller keeps running
	for (int i = 0; i < rows.size(); i++)
	begin
		row = rows[i];
		if (row.idle)
			repeat (IDLE_WAIT) @(negedge sysClk);
		sendFrame(row);
		reply = '0;
		for (int k = 0; k < 32'(row.len); k++)
		begin
			receiveByte(b);
			reply = {reply[23:0], b};
		end
		checkValue($sformatf("row %0d op %02h adrs %04h", i, row.op, row.adrs), row.exp, reply);
		// Rest of the last stop bit
		repeat (ctrlPkg::CLKS_PER_BIT) @(negedge sysClk);
	end

	if (microControllerBlock_inst.busArbiter_inst.busChk.assertFails == 0)
	begin
		$display("TEST PASSED");
		$finish;
	end
	else
		abortRun($sformatf("%0d bus timing assertions failed",
			microControllerBlock_inst.busArbiter_inst.busChk.assertFails));
end

endmodule

`default_nettype wire

// File: microControllerBlock.f
hdl/busPkg.sv
hdl/ctrlPkg.sv
hdl/uartLink.sv
hdl/hostCommandPort.sv
hdl/autoPoller.sv
hdl/busArbiter.sv
hdl/regSlave.sv
hdl/microControllerBlock.sv
bench/microControllerBlock_chk.sv
bench/microControllerBlock_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= microControllerBlock_tb
FILELIST  ?= microControllerBlock.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST PASSED

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
